// File: div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// data word width
// the divider datapath is built for 32 bits only
`define DIV_XLEN 32

// leading-zero count width for one word
`define DIV_CLZ_W 5

`endif

// File: div_pkg.sv
`include "div_defines.svh"

package div_pkg;

    // operand and result word
    typedef logic [`DIV_XLEN-1:0] word_t;

    // operand interpretation
    typedef enum logic {
        DIV_UNSIGNED = 1'b0,  // divu / remu
        DIV_SIGNED   = 1'b1   // div / rem
    } div_op_e;

endpackage

// File: clz.sv
`include "div_defines.svh"

module clz import div_pkg::*; (
    input  word_t                  clz_input,
    output logic [`DIV_CLZ_W-1:0] clz_out
);

    // word after each halving step, upper zeros shifted out
    word_t w16;
    word_t w8;
    word_t w4;

    // one count bit per search level, msb first
    logic z16;
    logic z8;
    logic z4;
    logic z2;
    logic z1;

    // upper 16 empty?
    assign z16 = (clz_input[31:16] == 16'h0000);
    assign w16 = z16 ? {clz_input[15:0], 16'h0000} : clz_input;

    // then the top byte of what is left
    assign z8 = (w16[31:24] == 8'h00);
    assign w8 = z8 ? {w16[23:0], 8'h00} : w16;

    // top nibble
    assign z4 = (w8[31:28] == 4'h0);
    assign w4 = z4 ? {w8[27:0], 4'h0} : w8;

    // top pair
    assign z2 = (w4[31:30] == 2'b00);

    // last bit, picked from the pair the z2 step would keep on top
    assign z1 = z2 ? ~w4[29] : ~w4[31];

    // all-zero input falls through every level and reads 31
    assign clz_out = {z16, z8, z4, z2, z1};

endmodule

// File: div_alu.sv
`include "div_defines.svh"

module div_alu import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  div_op_e op,
    input  word_t   dividend,
    input  word_t   divisor,
    input  logic    start,
    output logic    is_running,
    output logic    done,
    output word_t   quotient_out,
    output word_t   remainder_out
);

    localparam int CW  = `DIV_CLZ_W;
    localparam int MSB = `DIV_XLEN - 1;

    // sign handling
    logic  signed_op;
    logic  neg_dividend;
    logic  neg_divisor;
    logic  neg_quotient;     // operand signs differ
    logic  neg_remainder;    // follows the dividend
    word_t abs_dividend;
    word_t abs_divisor;

    // alignment
    logic [CW-1:0] dividend_clz;
    logic [CW-1:0] divisor_clz;
    logic [CW:0]   clz_diff;         // msb is the borrow
    logic          divisor_bigger;   // early exit
    logic [CW-1:0] align_shift;      // even part of clz_diff

    // datapath
    word_t            shifted_divisor;
    word_t            quotient;
    word_t            remainder;
    logic [MSB+2:0]   diff_2x;   // two spare msbs hold the sign
    logic [MSB+2:0]   diff_1x;
    logic             fit_2x;
    logic             fit_1x;

    // iteration control
    logic [CW-2:0] cycles_left;
    logic [CW-1:0] cycles_dec;   // borrow marks the last iteration
    logic          last_iter;
    logic          running;
    logic          running_q;
    logic          last_iter_q;
    logic          start_q;
    logic          divisor_bigger_q;

    // two's complement when neg is set
    function automatic word_t negate_if(input word_t value, input logic neg);
        negate_if = neg ? (~value + 1'b1) : value;
    endfunction

    assign signed_op     = (op == DIV_SIGNED);
    assign neg_dividend  = signed_op & dividend[MSB];
    assign neg_divisor   = signed_op & divisor[MSB];
    assign neg_quotient  = signed_op & (dividend[MSB] ^ divisor[MSB]);
    assign neg_remainder = neg_dividend;

    assign abs_dividend = negate_if(dividend, neg_dividend);   // 0x80000000 stays as is
    assign abs_divisor  = negate_if(divisor, neg_divisor);

    clz dividend_clz_i (
        .clz_input (abs_dividend),
        .clz_out   (dividend_clz)
    );

    clz divisor_clz_i (
        .clz_input (abs_divisor),
        .clz_out   (divisor_clz)
    );

    // divisor with fewer leading zeros is strictly larger
    assign clz_diff       = {1'b0, divisor_clz} - {1'b0, dividend_clz};
    assign divisor_bigger = clz_diff[CW];
    assign align_shift    = clz_diff[CW-1:0] & {{(CW-1){1'b1}}, 1'b0};   // round down to even

    // trial subtractions, 2x first then 1x on top of it
    assign diff_2x = {2'b00, remainder} - {1'b0, shifted_divisor, 1'b0};
    assign fit_2x  = (diff_2x[MSB+2:MSB+1] == 2'b00);
    assign diff_1x = fit_2x ? (diff_2x - {2'b00, shifted_divisor})      // tries 3x
                            : ({2'b00, remainder} - {2'b00, shifted_divisor});
    assign fit_1x  = (diff_1x[MSB+2:MSB+1] == 2'b00);

    // divisor alignment and step count load while idle
    always_ff @(posedge clk) begin
        if (running) begin
            shifted_divisor <= {2'b00, shifted_divisor[MSB:2]};   // one radix-4 digit down
            cycles_left     <= cycles_dec[CW-2:0];
        end else begin
            shifted_divisor <= abs_divisor << align_shift;
            cycles_left     <= align_shift[CW-1:1];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quotient <= '0;
        end else if (running) begin
            quotient <= {quotient[MSB-2:0], fit_2x, fit_1x};   // two bits per cycle
        end
    end

    // partial remainder only moves when some multiple fit
    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= abs_dividend;
        end else if (running) begin
            if (fit_1x) begin
                remainder <= diff_1x[MSB:0];
            end else if (fit_2x) begin
                remainder <= diff_2x[MSB:0];
            end
        end
    end

    assign cycles_dec = {1'b0, cycles_left} - 1'b1;
    assign last_iter  = cycles_dec[CW-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            running_q <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            running   <= (running & ~last_iter) | (start & ~divisor_bigger);
            running_q <= running;
            start_q   <= start;
        end
    end

    // qualified by running_q / start_q
    always_ff @(posedge clk) begin
        last_iter_q      <= last_iter;
        divisor_bigger_q <= divisor_bigger;
    end

    assign is_running = running;
    assign done       = (running_q & last_iter_q) | (start_q & divisor_bigger_q);

    // results read the held operands directly
    always_comb begin
        if (dividend == '0) begin
            quotient_out  = '0;
            remainder_out = '0;
        end else begin
            quotient_out  = negate_if(quotient, neg_quotient);
            remainder_out = negate_if(remainder, neg_remainder);
        end
    end

    // caller must wait for done before the next start
    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (rst) !(start && running)
    );

    a_no_done_while_running: assert property (
        @(posedge clk) disable iff (rst) !(done && running)
    );

endmodule

// File: div_unit.sv
module div_unit import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  div_op_e op,
    input  word_t   dividend,
    input  word_t   divisor,
    output logic    busy,
    output logic    resp_valid,
    output word_t   quotient,
    output word_t   remainder
);

    logic    accept;        // req seen while idle
    logic    finish;        // result ready this cycle
    logic    start;         // one-cycle kick to the core
    logic    bypass;        // zero divisor, core skipped
    div_op_e op_q;
    word_t   dividend_q;
    word_t   divisor_q;

    logic    alu_running;
    logic    alu_done;
    word_t   alu_quotient;
    word_t   alu_remainder;

    assign accept = req & ~busy;   // req during busy is dropped
    assign finish = alu_done | bypass;

    // operands stay put until the result is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= op;
            dividend_q <= dividend;
            divisor_q  <= divisor;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            start      <= 1'b0;
            bypass     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            start      <= accept & (divisor != '0);
            bypass     <= accept & (divisor == '0);
            resp_valid <= finish;                  // pulse the cycle after
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;                      // drops with resp_valid
            end
        end
    end

    // result held until the next response
    always_ff @(posedge clk) begin
        if (bypass) begin
            quotient  <= '1;             // riscv x/0 quotient
            remainder <= dividend_q;     // remainder is the dividend
        end else if (alu_done) begin
            quotient  <= alu_quotient;
            remainder <= alu_remainder;
        end
    end

    div_alu alu_i (
        .clk           (clk),
        .rst           (rst),
        .op            (op_q),
        .dividend      (dividend_q),
        .divisor       (divisor_q),
        .start         (start),
        .is_running    (alu_running),
        .done          (alu_done),
        .quotient_out  (alu_quotient),
        .remainder_out (alu_remainder)
    );

    // a response always closes an accepted request
    a_resp_needs_request: assert property (
        @(posedge clk) disable iff (rst) resp_valid |-> $past(busy)
    );

    // core activity only inside a pending request
    a_core_only_when_pending: assert property (
        @(posedge clk) disable iff (rst) (alu_running || alu_done) |-> busy
    );

endmodule

// File: tb_div_unit.sv
module tb_div_unit import div_pkg::*; ();

    logic    clk;
    logic    rst;
    logic    req;
    div_op_e op;
    word_t   dividend;
    word_t   divisor;
    logic    busy;
    logic    resp_valid;
    word_t   quotient;
    word_t   remainder;

    logic [63:0] expected_q[$];   // {quotient, remainder} per accepted request

    div_unit dut_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .dividend   (dividend),
        .divisor    (divisor),
        .busy       (busy),
        .resp_valid (resp_valid),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // riscv div/divu/rem/remu result packed as {quotient, remainder}
    function automatic logic [63:0] div_ref(input div_op_e kind, input word_t a, input word_t b);
        word_t q;
        word_t r;
        if (b == '0) begin
            q = '1;   // x/0 gives all ones
            r = a;
        end else if (kind == DIV_SIGNED && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;    // overflow wraps back to the dividend
            r = '0;
        end else if (kind == DIV_SIGNED) begin
            q = $signed(a) / $signed(b);   // truncates toward zero
            r = $signed(a) % $signed(b);   // takes the dividend's sign
        end else begin
            q = a / b;
            r = a % b;
        end
        return {q, r};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic word_t random_operand();
        word_t w;
        w = $urandom();
        return w >> $urandom_range(0, 31);   // spread the magnitudes
    endfunction

    // one-cycle req with its operands and the expected result queued
    task automatic send_request(input div_op_e kind, input word_t a, input word_t b);
        @(posedge clk);
        req      <= 1'b1;
        op       <= kind;
        dividend <= a;
        divisor  <= b;
        expected_q.push_back(div_ref(kind, a, b));
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            cycles++;
            if (cycles > 40) begin
                fail_run("timeout: no response arrived within 40 cycles");
            end
            @(negedge clk);
        end
    endtask

    task automatic run_case(input div_op_e kind, input word_t a, input word_t b);
        send_request(kind, a, b);
        wait_response();
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!busy && !resp_valid) else begin
                fail_run("busy or resp_valid high with no request issued");
            end
        end
    endtask

    // compare every response against the oldest accepted request
    always @(negedge clk) begin
        logic [63:0] expected;
        if (!rst && resp_valid) begin
            assert (expected_q.size() > 0) else begin
                fail_run("response arrived with no accepted request outstanding");
            end
            expected = expected_q.pop_front();
            assert (quotient == expected[63:32]) else begin
                fail_run($sformatf("mismatch quotient: got %08h expected %08h",
                                   quotient, expected[63:32]));
            end
            assert (remainder == expected[31:0]) else begin
                fail_run($sformatf("mismatch remainder: got %08h expected %08h",
                                   remainder, expected[31:0]));
            end
            assert (!busy) else begin
                fail_run("busy still high in the response cycle");
            end
        end
    end

    initial begin
        word_t a;
        word_t b;
        int    sel;
        void'($urandom(330));
        rst      = 1'b1;
        req      = 1'b0;
        op       = DIV_UNSIGNED;
        dividend = '0;
        divisor  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        check_idle(8);   // quiet until the first req

        // unsigned with mixed divisor sizes
        for (int i = 0; i < 300; i++) begin
            a   = random_operand();
            sel = $urandom_range(0, 3);
            if (sel == 0) begin
                b = $urandom_range(1, 15);            // small divisor
            end else if (sel == 1) begin
                b = a + $urandom_range(1, 1000);      // mostly above the dividend
            end else begin
                b = random_operand();
            end
            run_case(DIV_UNSIGNED, a, b);
        end

        // signed cycling through the four sign pairs
        for (int i = 0; i < 200; i++) begin
            a = random_operand() >> 1;
            b = random_operand() >> 1;
            if (i % 2 == 1) begin
                a = -a;
            end
            if (i % 4 >= 2) begin
                b = -b;
            end
            run_case(DIV_SIGNED, a, b);
        end

        // corners
        run_case(DIV_UNSIGNED, 32'h1234_5678, 32'h0);
        run_case(DIV_SIGNED,   32'hffff_fff9, 32'h0);
        run_case(DIV_UNSIGNED, 32'h0,         32'h0);
        run_case(DIV_UNSIGNED, 32'h0,         32'h0000_0005);
        run_case(DIV_SIGNED,   32'h0,         32'hffff_fffd);
        run_case(DIV_SIGNED,   32'h8000_0000, 32'hffff_ffff);   // signed overflow
        run_case(DIV_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
        run_case(DIV_UNSIGNED, 32'h0001_e240, 32'h0001_e240);
        run_case(DIV_SIGNED,   32'hffff_fff9, 32'hffff_fff9);
        run_case(DIV_SIGNED,   32'h8000_0000, 32'h8000_0000);
        run_case(DIV_UNSIGNED, 32'hdead_beef, 32'h1);
        run_case(DIV_SIGNED,   32'h8000_0000, 32'h1);
        run_case(DIV_SIGNED,   32'hffff_fffb, 32'h1);

        // second req lands while busy and must be dropped
        send_request(DIV_UNSIGNED, 32'hffff_ffff, 32'h1);   // longest core run
        @(posedge clk);
        req      <= 1'b1;
        op       <= DIV_SIGNED;
        dividend <= 32'h0000_1234;
        divisor  <= 32'h0000_0007;
        @(negedge clk);
        assert (busy) else begin
            fail_run("busy low while the first request is still running");
        end
        @(posedge clk);
        req <= 1'b0;
        wait_response();
        check_idle(30);   // no stray second response

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
div_pkg.sv
clz.sv
div_alu.sv
div_unit.sv
tb_div_unit.sv

// File: Makefile
TOP = tb_div_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only -Wall -I. --top-module div_unit div_pkg.sv clz.sv div_alu.sv div_unit.sv

clean:
	rm -rf obj_dir sim.log
